/* Makefile */
VERILATOR ?= verilator
TOP ?= hsi_tx_tb
RTL_TOP ?= hsi_tx_top
FLIST ?= all.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)

run: build
	@./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ]; then echo "simulation exited with status $$status"; exit 1; fi; \
	if grep -q "Test failed" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* all.f */
verilog/hsi_pkg.sv
verilog/hsi_tx_ctrl.sv
verilog/hsi_frame_builder.sv
verilog/hsi_crc16.sv
verilog/hsi_byte_coder.sv
verilog/hsi_tx_top.sv
verification/hsi_tx_tb.sv

/* verification/hsi_tx_tb.sv */
`default_nettype none

module hsi_tx_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int N_FRAMES = 30;
	localparam int QUIET_WAIT = 400;
	localparam int FRAME_SLOT = 12 * 45 + hsi_pkg::GAP_CYCLES + 10;
	localparam int WATCHDOG_NS = (N_FRAMES * FRAME_SLOT + 2 * QUIET_WAIT) * 8 * 2;

	logic clk;
	logic n_rst;
	logic tm_rdy;
	logic sr_rdy;
	logic ccw_rdy;
	logic tm_en;
	logic sr_en;
	logic btc_en;
	logic pre_tm;
	logic com_src;
	hsi_pkg::tm_word_t tm_word;
	hsi_pkg::sr_word_t sr_word;
	hsi_pkg::btc_t btc;
	hsi_pkg::byte_t ccw_d;
	wire tm_ack;
	wire sr_ack;
	wire ccw_ack;
	wire com1;
	wire com2;

	int seed = 91410;
	int err_value = 0;
	int err_other = 0;
	string test_name = "reset";
	hsi_pkg::byte_t exp_bytes[$];
	int exp_len[$];
	bit exp_line[$];
	int cur_idx = 0;
	int quiet = hsi_pkg::GAP_CYCLES;
	int tm_acks = 0;
	int sr_acks = 0;
	int ccw_acks = 0;
	int exp_tm_acks = 0;
	int exp_sr_acks = 0;
	int exp_ccw_acks = 0;
	// Frame level model of the time-code schedule
	int m_tm_cnt = 0;
	bit m_due = 1'b0;

	hsi_tx_top UUT
	(
		.clk(clk),
		.n_rst(n_rst),
		.tm_rdy(tm_rdy),
		.sr_rdy(sr_rdy),
		.ccw_rdy(ccw_rdy),
		.tm_en(tm_en),
		.sr_en(sr_en),
		.btc_en(btc_en),
		.pre_tm(pre_tm),
		.tm_word(tm_word),
		.sr_word(sr_word),
		.btc(btc),
		.ccw_d(ccw_d),
		.com_src(com_src),
		.tm_ack(tm_ack),
		.sr_ack(sr_ack),
		.ccw_ack(ccw_ack),
		.com1(com1),
		.com2(com2)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Cycles with both lines high
	always @(negedge clk)
	begin
		if (!(com1 && com2))
			quiet <= 0;
		else if (quiet < 1000000)
			quiet <= quiet + 1;
	end

	tm_ack_req: assert property (@(posedge clk) disable iff (!n_rst)
		tm_ack |-> $past(tm_rdy && tm_en))
		else begin err_other++; $display("tm_ack without an enabled TM request"); end
	sr_ack_req: assert property (@(posedge clk) disable iff (!n_rst)
		sr_ack |-> $past(sr_rdy && sr_en))
		else begin err_other++; $display("sr_ack without an enabled SR request"); end
	ccw_ack_req: assert property (@(posedge clk) disable iff (!n_rst)
		ccw_ack |-> $past(ccw_rdy && !pre_tm))
		else begin err_other++; $display("ccw_ack while pre_tm high or no request"); end

	function automatic hsi_pkg::crc_t crc_ccitt(input hsi_pkg::byte_t bytes[$]);
		hsi_pkg::crc_t c;
		c = 16'hFFFF;
		foreach (bytes[i])
		begin
			c = c ^ {bytes[i], 8'h00};
			for (int k = 0; k < 8; k++)
				c = c[15] ? ({c[14:0], 1'b0} ^ 16'h1021) : {c[14:0], 1'b0};
		end
		return c;
	endfunction

	function automatic logic line_val(input bit id);
		return id ? com1 : com2;
	endfunction

	task automatic push_frame(input hsi_pkg::msg_kind_e kind, input hsi_pkg::btc_t payload);
		hsi_pkg::byte_t f[$];
		hsi_pkg::crc_t c;
		int len;
		case (kind)
			hsi_pkg::MSG_TM:
			begin
				f.push_back(8'hA1);
				len = 4;
			end
			hsi_pkg::MSG_BTC:
			begin
				f.push_back(8'hB2);
				len = 5;
			end
			hsi_pkg::MSG_SR:
			begin
				f.push_back(8'hC3);
				len = 2;
			end
			default:
			begin
				f.push_back(8'hD4);
				len = 1;
			end
		endcase
		for (int i = len - 1; i >= 0; i--)
			f.push_back(payload[8*i +: 8]);
		c = crc_ccitt(f);
		f.push_back(c[15:8]);
		f.push_back(c[7:0]);
		foreach (f[i])
			exp_bytes.push_back(f[i]);
		exp_len.push_back(f.size());
		exp_line.push_back(com_src);
	endtask

	// Expected frame order for the requests pending now
	task automatic predict();
		bit p_tm;
		bit p_sr;
		bit p_ccw;
		bit done;
		p_tm = tm_rdy && tm_en;
		p_sr = sr_rdy && sr_en;
		p_ccw = ccw_rdy && !pre_tm;
		done = 1'b0;
		while (!done)
		begin
			if (p_tm)
			begin
				push_frame(hsi_pkg::MSG_TM, {8'h00, tm_word});
				p_tm = 1'b0;
				exp_tm_acks++;
				m_tm_cnt++;
				if (m_tm_cnt == 4)
				begin
					m_tm_cnt = 0;
					m_due = 1'b1;
				end
			end
			else if (m_due && btc_en)
			begin
				push_frame(hsi_pkg::MSG_BTC, btc);
				m_due = 1'b0;
			end
			else if (p_sr)
			begin
				push_frame(hsi_pkg::MSG_SR, {24'h0, sr_word});
				p_sr = 1'b0;
				exp_sr_acks++;
			end
			else if (p_ccw)
			begin
				push_frame(hsi_pkg::MSG_CCW, {32'h0, ccw_d});
				p_ccw = 1'b0;
				exp_ccw_acks++;
			end
			else
				done = 1'b1;
		end
	endtask

	task automatic take_byte(input bit id, input hsi_pkg::byte_t data, input logic par,
		input logic stp, input int q);
		hsi_pkg::byte_t exp;
		logic exp_par;
		if (cur_idx == 0)
		begin
			if (exp_len.size() == 0)
			begin
				err_other++;
				$display("a byte appeared on com%0d while no frame was expected", id ? 1 : 2);
				return;
			end
			assert (q >= hsi_pkg::GAP_CYCLES)
			else begin err_value++; $display("ERROR %s gap exp >= %0d act %0d", test_name,
				hsi_pkg::GAP_CYCLES, q); end
			assert (id == exp_line[0])
			else begin err_value++; $display("ERROR %s line exp %0d act %0d", test_name,
				exp_line[0], id); end
		end
		exp = exp_bytes.pop_front();
		// Odd parity makes the total count of ones odd
		exp_par = ($countones(data) % 2 == 0);
		assert (data == exp)
		else begin err_value++; $display("ERROR %s byte %0d exp %h act %h", test_name,
			cur_idx, exp, data); end
		assert (par == exp_par)
		else begin err_value++; $display("ERROR %s parity exp %b act %b", test_name,
			exp_par, par); end
		assert (stp == 1'b1)
		else begin err_value++; $display("ERROR %s stop exp 1 act %b", test_name, stp); end
		cur_idx++;
		if (cur_idx == exp_len[0])
		begin
			cur_idx = 0;
			void'(exp_len.pop_front());
			void'(exp_line.pop_front());
		end
	endtask

	// Samples each bit one and a half clocks after its edge
	task automatic decode_line(input bit id);
		hsi_pkg::byte_t data;
		logic par;
		logic stp;
		int q;
		forever
		begin
			@(negedge clk);
			if (n_rst && line_val(id) == 1'b0)
			begin
				q = quiet;
				@(negedge clk);
				for (int i = 0; i < 8; i++)
				begin
					repeat (hsi_pkg::BIT_CYCLES) @(negedge clk);
					data[i] = line_val(id);
				end
				repeat (hsi_pkg::BIT_CYCLES) @(negedge clk);
				par = line_val(id);
				repeat (hsi_pkg::BIT_CYCLES) @(negedge clk);
				stp = line_val(id);
				take_byte(id, data, par, stp, q);
			end
		end
	endtask

	// One clock; sources drop their request on the acknowledge
	task automatic tick();
		@(negedge clk);
		if (tm_ack)
		begin
			tm_rdy = 1'b0;
			tm_acks++;
		end
		if (sr_ack)
		begin
			sr_rdy = 1'b0;
			sr_acks++;
		end
		if (ccw_ack)
		begin
			ccw_rdy = 1'b0;
			ccw_acks++;
		end
	endtask

	task automatic wait_frames();
		while (exp_len.size() != 0)
			tick();
		repeat (hsi_pkg::GAP_CYCLES + 10) tick();
	endtask

	task automatic new_payloads();
		tm_word = 32'($random(seed));
		sr_word = 16'($random(seed));
		btc = {8'($random(seed)), 32'($random(seed))};
		ccw_d = 8'($random(seed));
		com_src = 1'($random(seed));
	endtask

	task automatic send_tm();
		new_payloads();
		tm_rdy = 1'b1;
		predict();
		wait_frames();
	endtask

	initial
	begin
		fork
			decode_line(1'b1);
			decode_line(1'b0);
		join_none
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the tests finished");
		$display("Test failed");
		$finish;
	end

	initial
	begin
		n_rst = 1'b0;
		tm_rdy = 1'b0;
		sr_rdy = 1'b0;
		ccw_rdy = 1'b0;
		tm_en = 1'b1;
		sr_en = 1'b1;
		btc_en = 1'b1;
		pre_tm = 1'b0;
		com_src = 1'b1;
		tm_word = '0;
		sr_word = '0;
		btc = '0;
		ccw_d = '0;
		repeat (8) @(negedge clk);
		n_rst = 1'b1;
		repeat (20) tick();

		test_name = "content";
		send_tm();
		new_payloads();
		sr_rdy = 1'b1;
		predict();
		wait_frames();
		new_payloads();
		ccw_rdy = 1'b1;
		predict();
		wait_frames();

		test_name = "priority";
		new_payloads();
		tm_rdy = 1'b1;
		sr_rdy = 1'b1;
		ccw_rdy = 1'b1;
		predict();
		wait_frames();

		test_name = "btc_sched";
		repeat (6) send_tm();
		btc_en = 1'b0;
		repeat (5) send_tm();

		test_name = "ccw_block";
		pre_tm = 1'b1;
		new_payloads();
		ccw_rdy = 1'b1;
		predict();
		repeat (QUIET_WAIT) tick();
		pre_tm = 1'b0;
		predict();
		wait_frames();

		test_name = "disabled";
		tm_en = 1'b0;
		sr_en = 1'b0;
		tm_rdy = 1'b1;
		sr_rdy = 1'b1;
		predict();
		repeat (QUIET_WAIT) tick();
		tm_rdy = 1'b0;
		sr_rdy = 1'b0;
		tm_en = 1'b1;
		sr_en = 1'b1;

		// Time code is due here, so it must go between TM and SR
		test_name = "btc_enable";
		new_payloads();
		btc_en = 1'b1;
		tm_rdy = 1'b1;
		sr_rdy = 1'b1;
		ccw_rdy = 1'b1;
		predict();
		wait_frames();

		assert (exp_len.size() == 0 && cur_idx == 0)
		else begin err_other++; $display("expected frames were never sent"); end
		assert (tm_acks == exp_tm_acks)
		else begin err_value++; $display("ERROR tm_ack count exp %0d act %0d", exp_tm_acks,
			tm_acks); end
		assert (sr_acks == exp_sr_acks)
		else begin err_value++; $display("ERROR sr_ack count exp %0d act %0d", exp_sr_acks,
			sr_acks); end
		assert (ccw_acks == exp_ccw_acks)
		else begin err_value++; $display("ERROR ccw_ack count exp %0d act %0d",
			exp_ccw_acks, ccw_acks); end

		$display("errors: %0d wrong values, %0d other failures", err_value, err_other);
		if (err_value + err_other == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog/hsi_byte_coder.sv */
`default_nettype none

module hsi_byte_coder
(
	input wire clk,
	input wire n_rst,
	input wire hsi_pkg::byte_req_t byte_req,
	input wire com_src,
	output logic busy,
	output logic byte_done,
	output logic com1,
	output logic com2
);

	typedef logic [$clog2(hsi_pkg::BIT_CYCLES)-1:0] cyc_t;
	typedef logic [$clog2(hsi_pkg::FRAME_BITS)-1:0] bit_t;

	hsi_pkg::coder_state_e state;
	cyc_t cyc_cnt;
	bit_t bit_cnt;
	logic [hsi_pkg::FRAME_BITS-2:0] shift;
	logic line;
	logic sel;
	logic bit_end;

	assign bit_end = (cyc_cnt == cyc_t'(hsi_pkg::BIT_CYCLES - 1));
	assign busy = (state == hsi_pkg::CD_SHIFT);
	assign byte_done = busy && bit_end && (bit_cnt == bit_t'(hsi_pkg::FRAME_BITS - 1));

	// Unselected line stays at idle level
	assign com1 = sel ? line : 1'b1;
	assign com2 = sel ? 1'b1 : line;

	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
		begin
			state <= hsi_pkg::CD_IDLE;
			cyc_cnt <= '0;
			bit_cnt <= '0;
			line <= 1'b1;
			sel <= 1'b1;
		end
		else
		begin
			case (state)
				hsi_pkg::CD_IDLE:
				begin
					if (byte_req.valid)
					begin
						state <= hsi_pkg::CD_SHIFT;
						cyc_cnt <= '0;
						bit_cnt <= '0;
						line <= 1'b0;
						sel <= com_src;
					end
				end
				default:
				begin
					cyc_cnt <= cyc_cnt + cyc_t'(1);
					if (bit_end)
					begin
						cyc_cnt <= '0;
						if (byte_done)
						begin
							state <= hsi_pkg::CD_IDLE;
							line <= 1'b1;
						end
						else
						begin
							bit_cnt <= bit_cnt + bit_t'(1);
							line <= shift[0];
						end
					end
				end
			endcase
		end
	end

	// Data LSB first, then odd parity and stop
	always_ff @(posedge clk)
	begin
		if (state == hsi_pkg::CD_IDLE && byte_req.valid)
			shift <= {1'b1, ~^byte_req.data, byte_req.data};
		else if (busy && bit_end)
			shift <= {1'b1, shift[hsi_pkg::FRAME_BITS-2:1]};
	end

	valid_when_idle: assert property (@(posedge clk) disable iff (!n_rst)
		byte_req.valid |-> !busy)
		else $error("byte valid while coder busy");

endmodule

`default_nettype wire

/* verilog/hsi_crc16.sv */
`default_nettype none

module hsi_crc16
(
	input wire clk,
	input wire n_rst,
	input wire crc_clear,
	input wire hsi_pkg::byte_req_t crc_req,
	output hsi_pkg::crc_t crc
);

	logic valid_d;
	logic take;
	logic fb;
	hsi_pkg::crc_t nxt;

	// Only the first cycle of a held valid counts
	assign take = crc_req.valid && !valid_d;

	always_comb
	begin
		nxt = crc;
		for (int i = 7; i >= 0; i--)
		begin
			fb = nxt[15] ^ crc_req.data[i];
			nxt = {nxt[14:0], 1'b0};
			if (fb)
				nxt = nxt ^ hsi_pkg::CRC_POLY;
		end
	end

	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
		begin
			valid_d <= 1'b0;
			crc <= hsi_pkg::CRC_INIT;
		end
		else
		begin
			valid_d <= crc_req.valid;
			if (crc_clear)
				crc <= hsi_pkg::CRC_INIT;
			else if (take)
				crc <= nxt;
		end
	end

endmodule

`default_nettype wire

/* verilog/hsi_frame_builder.sv */
`default_nettype none

module hsi_frame_builder
(
	input wire clk,
	input wire n_rst,
	input wire hsi_pkg::frame_req_t frame_req,
	input wire hsi_pkg::crc_t crc,
	input wire byte_done,
	output hsi_pkg::byte_req_t byte_req,
	output hsi_pkg::byte_req_t crc_req,
	output logic frame_done
);

	typedef logic [2:0] idx_t;

	logic active;
	logic issue;
	logic last;
	idx_t idx;
	idx_t len;
	idx_t pl_sel;
	hsi_pkg::msg_kind_e kind_q;
	hsi_pkg::btc_t payload_q;
	hsi_pkg::byte_t hdr;
	hsi_pkg::byte_t cur_byte;

	always_comb
	begin
		case (kind_q)
			hsi_pkg::MSG_TM:
			begin
				len = idx_t'(hsi_pkg::LEN_TM);
				hdr = hsi_pkg::HDR_TM;
			end
			hsi_pkg::MSG_BTC:
			begin
				len = idx_t'(hsi_pkg::LEN_BTC);
				hdr = hsi_pkg::HDR_BTC;
			end
			hsi_pkg::MSG_SR:
			begin
				len = idx_t'(hsi_pkg::LEN_SR);
				hdr = hsi_pkg::HDR_SR;
			end
			default:
			begin
				len = idx_t'(hsi_pkg::LEN_CCW);
				hdr = hsi_pkg::HDR_CCW;
			end
		endcase
	end

	// Index 0 is the header, payload goes most significant byte first, CRC last
	always_comb
	begin
		pl_sel = len - idx;
		if (idx == '0)
			cur_byte = hdr;
		else if (idx <= len)
			cur_byte = payload_q[{pl_sel, 3'b000} +: 8];
		else if (idx == len + idx_t'(1))
			cur_byte = crc[15:8];
		else
			cur_byte = crc[7:0];
	end

	assign last = (idx == len + idx_t'(2));
	assign byte_req = '{issue, cur_byte};
	assign crc_req = '{issue && (idx <= len), cur_byte};
	assign frame_done = active && byte_done && last;

	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
		begin
			active <= 1'b0;
			issue <= 1'b0;
			idx <= '0;
			kind_q <= hsi_pkg::MSG_TM;
		end
		else
		begin
			issue <= 1'b0;
			if (frame_req.start)
			begin
				active <= 1'b1;
				issue <= 1'b1;
				idx <= '0;
				kind_q <= frame_req.kind;
			end
			else if (active && byte_done)
			begin
				if (last)
					active <= 1'b0;
				else
				begin
					idx <= idx + idx_t'(1);
					issue <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (frame_req.start)
			payload_q <= frame_req.payload;
	end

	no_overlap: assert property (@(posedge clk) disable iff (!n_rst)
		frame_req.start |-> !active)
		else $error("frame start while a frame is in progress");

endmodule

`default_nettype wire

/* verilog/hsi_pkg.sv */
`default_nettype none

package hsi_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [15:0] crc_t;
	typedef logic [31:0] tm_word_t;
	typedef logic [15:0] sr_word_t;
	typedef logic [39:0] btc_t;

	typedef enum logic [1:0]
	{
		MSG_TM,
		MSG_BTC,
		MSG_SR,
		MSG_CCW
	} msg_kind_e;

	typedef enum logic [1:0]
	{
		TX_IDLE,
		TX_SEND,
		TX_GAP
	} tx_state_e;

	typedef enum logic
	{
		CD_IDLE,
		CD_SHIFT
	} coder_state_e;

	// Shorter payloads sit in the low bytes
	typedef struct packed
	{
		logic start;
		msg_kind_e kind;
		btc_t payload;
	} frame_req_t;

	typedef struct packed
	{
		logic valid;
		byte_t data;
	} byte_req_t;

	// Line timing
	localparam int BIT_CYCLES = 4;
	localparam int FRAME_BITS = 11;
	localparam int GAP_CYCLES = 100;
	localparam int TM_PER_BTC = 4;

	localparam crc_t CRC_INIT = 16'hFFFF;
	localparam crc_t CRC_POLY = 16'h1021;

	localparam byte_t HDR_TM = 8'hA1;
	localparam byte_t HDR_BTC = 8'hB2;
	localparam byte_t HDR_SR = 8'hC3;
	localparam byte_t HDR_CCW = 8'hD4;

	// Payload bytes per message kind
	localparam int LEN_TM = 4;
	localparam int LEN_BTC = 5;
	localparam int LEN_SR = 2;
	localparam int LEN_CCW = 1;

endpackage

`default_nettype wire

/* verilog/hsi_tx_ctrl.sv */
`default_nettype none

module hsi_tx_ctrl
(
	input wire clk,
	input wire n_rst,
	input wire tm_rdy,
	input wire sr_rdy,
	input wire ccw_rdy,
	input wire tm_en,
	input wire sr_en,
	input wire btc_en,
	input wire pre_tm,
	input wire hsi_pkg::tm_word_t tm_word,
	input wire hsi_pkg::sr_word_t sr_word,
	input wire hsi_pkg::btc_t btc,
	input wire hsi_pkg::byte_t ccw_d,
	input wire frame_done,
	output logic tm_ack,
	output logic sr_ack,
	output logic ccw_ack,
	output hsi_pkg::frame_req_t frame_req
);

	hsi_pkg::tx_state_e state;
	logic [$clog2(hsi_pkg::GAP_CYCLES)-1:0] gap_cnt;
	logic [$clog2(hsi_pkg::TM_PER_BTC)-1:0] tm_cnt;
	logic btc_due;
	logic start_q;
	hsi_pkg::msg_kind_e kind_q;
	hsi_pkg::btc_t payload_q;
	logic grant;
	hsi_pkg::msg_kind_e sel_kind;
	hsi_pkg::btc_t sel_payload;

	assign frame_req = '{start_q, kind_q, payload_q};

	// Fixed priority: TM, time code, SR, then CCW outside pre_tm
	always_comb
	begin
		grant = 1'b1;
		sel_kind = hsi_pkg::MSG_TM;
		sel_payload = hsi_pkg::btc_t'(tm_word);
		if (tm_en && tm_rdy)
			sel_kind = hsi_pkg::MSG_TM;
		else if (btc_en && btc_due)
		begin
			sel_kind = hsi_pkg::MSG_BTC;
			sel_payload = btc;
		end
		else if (sr_en && sr_rdy)
		begin
			sel_kind = hsi_pkg::MSG_SR;
			sel_payload = hsi_pkg::btc_t'(sr_word);
		end
		else if (!pre_tm && ccw_rdy)
		begin
			sel_kind = hsi_pkg::MSG_CCW;
			sel_payload = hsi_pkg::btc_t'(ccw_d);
		end
		else
			grant = 1'b0;
	end

	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
		begin
			state <= hsi_pkg::TX_IDLE;
			start_q <= 1'b0;
			kind_q <= hsi_pkg::MSG_TM;
			tm_ack <= 1'b0;
			sr_ack <= 1'b0;
			ccw_ack <= 1'b0;
			gap_cnt <= '0;
		end
		else
		begin
			start_q <= 1'b0;
			tm_ack <= 1'b0;
			sr_ack <= 1'b0;
			ccw_ack <= 1'b0;
			case (state)
				hsi_pkg::TX_IDLE:
				begin
					if (grant)
					begin
						state <= hsi_pkg::TX_SEND;
						start_q <= 1'b1;
						kind_q <= sel_kind;
						tm_ack <= (sel_kind == hsi_pkg::MSG_TM);
						sr_ack <= (sel_kind == hsi_pkg::MSG_SR);
						ccw_ack <= (sel_kind == hsi_pkg::MSG_CCW);
					end
				end
				hsi_pkg::TX_SEND:
				begin
					if (frame_done)
					begin
						state <= hsi_pkg::TX_GAP;
						gap_cnt <= ($bits(gap_cnt))'(hsi_pkg::GAP_CYCLES - 1);
					end
				end
				hsi_pkg::TX_GAP:
				begin
					if (gap_cnt == '0)
						state <= hsi_pkg::TX_IDLE;
					else
						gap_cnt <= gap_cnt - 1'b1;
				end
				default:
					state <= hsi_pkg::TX_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == hsi_pkg::TX_IDLE && grant)
			payload_q <= sel_payload;
	end

	// Time code becomes due after every TM_PER_BTC finished telemetry frames
	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
		begin
			tm_cnt <= '0;
			btc_due <= 1'b0;
		end
		else
		begin
			if (frame_done && kind_q == hsi_pkg::MSG_TM)
			begin
				if (tm_cnt == ($bits(tm_cnt))'(hsi_pkg::TM_PER_BTC - 1))
				begin
					tm_cnt <= '0;
					btc_due <= 1'b1;
				end
				else
					tm_cnt <= tm_cnt + 1'b1;
			end
			else if (state == hsi_pkg::TX_IDLE && grant && sel_kind == hsi_pkg::MSG_BTC)
				btc_due <= 1'b0;
		end
	end

	ack_onehot: assert property (@(posedge clk) disable iff (!n_rst)
		$onehot0({tm_ack, sr_ack, ccw_ack}))
		else $error("more than one acknowledge high");

	start_from_idle: assert property (@(posedge clk) disable iff (!n_rst)
		frame_req.start |-> $past(state) == hsi_pkg::TX_IDLE)
		else $error("frame start outside IDLE");

endmodule

`default_nettype wire

/* verilog/hsi_tx_top.sv */
`default_nettype none

module hsi_tx_top
(
	input wire clk,
	input wire n_rst,
	input wire tm_rdy,
	input wire sr_rdy,
	input wire ccw_rdy,
	input wire tm_en,
	input wire sr_en,
	input wire btc_en,
	input wire pre_tm,
	input wire hsi_pkg::tm_word_t tm_word,
	input wire hsi_pkg::sr_word_t sr_word,
	input wire hsi_pkg::btc_t btc,
	input wire hsi_pkg::byte_t ccw_d,
	input wire com_src,
	output wire tm_ack,
	output wire sr_ack,
	output wire ccw_ack,
	output wire com1,
	output wire com2
);

	wire hsi_pkg::frame_req_t frame_req;
	wire hsi_pkg::byte_req_t byte_req;
	wire hsi_pkg::byte_req_t crc_req;
	wire hsi_pkg::crc_t crc;
	wire frame_done;
	wire byte_done;

	hsi_tx_ctrl u_ctrl
	(
		.clk(clk),
		.n_rst(n_rst),
		.tm_rdy(tm_rdy),
		.sr_rdy(sr_rdy),
		.ccw_rdy(ccw_rdy),
		.tm_en(tm_en),
		.sr_en(sr_en),
		.btc_en(btc_en),
		.pre_tm(pre_tm),
		.tm_word(tm_word),
		.sr_word(sr_word),
		.btc(btc),
		.ccw_d(ccw_d),
		.frame_done(frame_done),
		.tm_ack(tm_ack),
		.sr_ack(sr_ack),
		.ccw_ack(ccw_ack),
		.frame_req(frame_req)
	);

	hsi_frame_builder u_builder
	(
		.clk(clk),
		.n_rst(n_rst),
		.frame_req(frame_req),
		.crc(crc),
		.byte_done(byte_done),
		.byte_req(byte_req),
		.crc_req(crc_req),
		.frame_done(frame_done)
	);

	// Cleared by the frame start strobe
	hsi_crc16 u_crc
	(
		.clk(clk),
		.n_rst(n_rst),
		.crc_clear(frame_req.start),
		.crc_req(crc_req),
		.crc(crc)
	);

	hsi_byte_coder u_coder
	(
		.clk(clk),
		.n_rst(n_rst),
		.byte_req(byte_req),
		.com_src(com_src),
		.busy(),
		.byte_done(byte_done),
		.com1(com1),
		.com2(com2)
	);

endmodule

`default_nettype wire
